/* cfi_trace_subsystem.f */
+incdir+source
source/cfi_trace_pkg.sv
source/trace_stream_if.sv
source/trace_pop_if.sv
source/trace_formatter.sv
source/trace_fifo.sv
source/trace_reader.sv
source/cfi_trace_subsystem.sv
test/tb_cfi_trace_subsystem.sv

/* test/tb_cfi_trace_subsystem.sv */
// Testbench for the trace capture top: clock, reset, stimulus tasks, reference model, checks
`timescale 1ns/1ps
`include "cfi_trace_defs.svh"
`default_nettype none

module tb_cfi_trace_subsystem;
  import cfi_trace_pkg::*;

  localparam int NumCores = `CFI_TRACE_NUM_CORES;
  localparam int Depth    = `CFI_TRACE_FIFO_DEPTH;
  // Cycle budget of reset and the five tests
  localparam int TestCycles = 16 + 8 + 30 + 30 + 40 + 40;

  logic                clk_i;
  logic                ndmreset_n;
  logic                core_select_i;
  pc_t                 pc_src_i   [NumCores-1:0];
  pc_t                 pc_dst_i   [NumCores-1:0];
  meta_t               metadata_i [NumCores-1:0];
  priv_lvl_t           priv_lvl_i [NumCores-1:0];
  word_t               instr_i    [NumCores-1:0];
  logic [NumCores-1:0] pc_valid_i;
  logic                read_i;
  level_t              watermark_i;
  logic                rd_valid_o;
  trace_t              rd_trace_o;
  logic                watermark_irq_o;
  word_t               dropped_count_o;

  // Reference model state
  trace_t exp_q [$];
  trace_t stage_rec;
  logic   stage_valid;
  trace_t exp_rd;
  logic   exp_valid;
  logic   exp_irq;
  word_t  exp_drop;
  logic   do_pop;
  logic   do_push;

  int err_cnt;
  int err_mark;
  int pass_cnt;
  int fail_cnt;

  cfi_trace_subsystem dut_i (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .core_select_i   ( core_select_i   ),
    .pc_src_i        ( pc_src_i        ),
    .pc_dst_i        ( pc_dst_i        ),
    .metadata_i      ( metadata_i      ),
    .priv_lvl_i      ( priv_lvl_i      ),
    .instr_i         ( instr_i         ),
    .pc_valid_i      ( pc_valid_i      ),
    .read_i          ( read_i          ),
    .watermark_i     ( watermark_i     ),
    .rd_valid_o      ( rd_valid_o      ),
    .rd_trace_o      ( rd_trace_o      ),
    .watermark_irq_o ( watermark_irq_o ),
    .dropped_count_o ( dropped_count_o )
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic trace_t format_record(pc_t src, pc_t dst, meta_t meta,
                                           priv_lvl_t priv, word_t op);
    trace_t r;
    r.priv_lvl = priv;
    // Bit 63 and bit 0 cleared
    r.pc_src_h = word_t'(src >> 32) & 32'h7fff_ffff;
    r.pc_src_l = word_t'(src) & 32'hffff_fffe;
    r.pc_dst_h = word_t'(dst >> 32) & 32'h7fff_ffff;
    r.pc_dst_l = word_t'(dst) & 32'hffff_fffe;
    r.metadata = word_t'(meta);
    r.opcode   = op;
    return r;
  endfunction

  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      exp_q.delete();
      stage_valid <= 1'b0;
      exp_valid   <= 1'b0;
      exp_irq     <= 1'b0;
      exp_drop    <= '0;
    end else begin
      do_pop  = read_i && (exp_q.size() > 0);
      do_push = stage_valid && ((exp_q.size() < Depth) || do_pop);
      // Interrupt follows the level held before this edge
      exp_irq   <= (exp_q.size() >= int'(watermark_i));
      exp_valid <= do_pop;
      if (do_pop) begin
        exp_rd <= exp_q.pop_front();
      end
      if (do_push) begin
        exp_q.push_back(stage_rec);
      end else if (stage_valid && (exp_drop != '1)) begin
        exp_drop <= exp_drop + 1;
      end
      stage_valid <= pc_valid_i[core_select_i];
      stage_rec   <= format_record(pc_src_i[core_select_i], pc_dst_i[core_select_i],
                                   metadata_i[core_select_i], priv_lvl_i[core_select_i],
                                   instr_i[core_select_i]);
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Mid-cycle sampling sees the reset values settled
  a_reset_values: assert property (@(negedge clk_i)
    !ndmreset_n |-> (!rd_valid_o && !watermark_irq_o && (dropped_count_o == '0)))
    else begin
      err_cnt++;
      $display("Error %0t: outputs not cleared during reset", $time);
    end

  a_rd_valid: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rd_valid_o == exp_valid)
    else begin
      err_cnt++;
      $display("Error %0t: rd_valid_o is %b, expected %b", $time, rd_valid_o, exp_valid);
    end

  a_rd_trace: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rd_valid_o |-> (rd_trace_o == exp_rd))
    else begin
      err_cnt++;
      $display("Error %0t: rd_trace_o is %h, expected %h", $time, rd_trace_o, exp_rd);
    end

  a_watermark: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    watermark_irq_o == exp_irq)
    else begin
      err_cnt++;
      $display("Error %0t: watermark_irq_o is %b, expected %b", $time,
               watermark_irq_o, exp_irq);
    end

  a_drop_count: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    dropped_count_o == exp_drop)
    else begin
      err_cnt++;
      $display("Error %0t: dropped_count_o is %0d, expected %0d", $time,
               dropped_count_o, exp_drop);
    end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic drive_trace(input int core);
    int p;
    @(negedge clk_i);
    for (int c = 0; c < NumCores; c++) begin
      pc_src_i[c]   = {$urandom, $urandom};
      pc_dst_i[c]   = {$urandom, $urandom};
      metadata_i[c] = meta_t'($urandom);
      instr_i[c]    = $urandom;
      p             = $urandom % 3;
      priv_lvl_i[c] = (p == 2) ? PRIV_LVL_M : priv_lvl_t'(p);
    end
    pc_valid_i       = '0;
    pc_valid_i[core] = 1'b1;
    @(negedge clk_i);
    pc_valid_i = '0;
  endtask

  task automatic issue_reads(input int n);
    repeat (n) begin
      @(negedge clk_i);
      read_i = 1'b1;
    end
    @(negedge clk_i);
    read_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_mark) begin
      pass_cnt++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      fail_cnt++;
      $display("[%0t] %s: failed with %0d errors", $time, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    void'($urandom(32'hb369));
    clk_i         = 1'b0;
    ndmreset_n    = 1'b0;
    core_select_i = 1'b0;
    pc_valid_i    = '0;
    read_i        = 1'b0;
    watermark_i   = level_t'(15);
    for (int c = 0; c < NumCores; c++) begin
      pc_src_i[c]   = '0;
      pc_dst_i[c]   = '0;
      metadata_i[c] = '0;
      priv_lvl_i[c] = PRIV_LVL_U;
      instr_i[c]    = '0;
    end
    repeat (16) @(negedge clk_i);
    ndmreset_n = 1'b1;

    idle_cycles(2);
    issue_reads(1);
    idle_cycles(3);
    end_test("reset values and empty read");

    repeat (6) drive_trace(0);
    idle_cycles(4);
    issue_reads(6);
    idle_cycles(3);
    end_test("core 0 records in order");

    @(negedge clk_i);
    core_select_i = 1'b1;
    repeat (3) begin
      drive_trace(0);
      drive_trace(1);
    end
    idle_cycles(4);
    // One read more than expected records
    issue_reads(4);
    idle_cycles(3);
    end_test("core 1 selected, core 0 ignored");

    @(negedge clk_i);
    core_select_i = 1'b0;
    repeat (Depth + 3) drive_trace(0);
    idle_cycles(4);
    issue_reads(Depth);
    idle_cycles(3);
    end_test("overflow drops three records");

    @(negedge clk_i);
    watermark_i = level_t'(4);
    repeat (5) drive_trace(0);
    idle_cycles(4);
    repeat (5) begin
      issue_reads(1);
      idle_cycles(2);
    end
    idle_cycles(3);
    end_test("watermark interrupt rise and fall");

    $display("Summary: %0d tests ok, %0d tests failed", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_cnt == 0)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #((TestCycles + 100) * 10);
    $display("Timeout: the tests did not finish within %0d cycles", TestCycles + 100);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* source/cfi_trace_subsystem.sv */
// Control-flow trace capture top: formatter, record FIFO and reader on plain ports
`timescale 1ns/1ps
`include "cfi_trace_defs.svh"
`default_nettype none

module cfi_trace_subsystem (
  input  logic                            clk_i,
  input  logic                            ndmreset_n,
  // Core trace inputs
  input  logic                            core_select_i,
  input  cfi_trace_pkg::pc_t              pc_src_i   [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::pc_t              pc_dst_i   [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::meta_t            metadata_i [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::priv_lvl_t        priv_lvl_i [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::word_t            instr_i    [`CFI_TRACE_NUM_CORES-1:0],
  input  logic [`CFI_TRACE_NUM_CORES-1:0] pc_valid_i,
  // Read side
  input  logic                            read_i,
  input  cfi_trace_pkg::level_t           watermark_i,
  output logic                            rd_valid_o,
  output cfi_trace_pkg::trace_t           rd_trace_o,
  output logic                            watermark_irq_o,
  output cfi_trace_pkg::word_t            dropped_count_o
);
  import cfi_trace_pkg::*;

  trace_stream_if stream_if ();
  trace_pop_if    pop_if ();

  // --------------------------------------------------------------------------
  // Capture
  // --------------------------------------------------------------------------
  trace_formatter i_trace_formatter (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .core_select_i ( core_select_i ),
    .pc_src_i      ( pc_src_i      ),
    .pc_dst_i      ( pc_dst_i      ),
    .metadata_i    ( metadata_i    ),
    .priv_lvl_i    ( priv_lvl_i    ),
    .instr_i       ( instr_i       ),
    .pc_valid_i    ( pc_valid_i    ),
    .stream_o      ( stream_if     )
  );

  trace_fifo i_trace_fifo (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .stream_i        ( stream_if       ),
    .pop_o           ( pop_if          ),
    .dropped_count_o ( dropped_count_o )
  );

  // --------------------------------------------------------------------------
  // Readout
  // --------------------------------------------------------------------------
  trace_reader i_trace_reader (
    .clk_i           ( clk_i           ),
    .ndmreset_n      ( ndmreset_n      ),
    .read_i          ( read_i          ),
    .watermark_i     ( watermark_i     ),
    .pop_i           ( pop_if          ),
    .rd_valid_o      ( rd_valid_o      ),
    .rd_trace_o      ( rd_trace_o      ),
    .watermark_irq_o ( watermark_irq_o )
  );

endmodule

`default_nettype wire

/* source/trace_reader.sv */
// Read strobe to FIFO pop, registered read data and watermark interrupt
`timescale 1ns/1ps
`default_nettype none

module trace_reader (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  read_i,
  input  cfi_trace_pkg::level_t watermark_i,
  trace_pop_if.reader           pop_i,
  output logic                  rd_valid_o,
  output cfi_trace_pkg::trace_t rd_trace_o,
  output logic                  watermark_irq_o
);
  import cfi_trace_pkg::*;

  logic   pop;
  logic   rd_valid_q;
  logic   irq_q;
  trace_t rd_trace_q;

  // Reads on an empty FIFO are ignored
  assign pop       = read_i && !pop_i.empty;
  assign pop_i.pop = pop;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_valid_q <= 1'b0;
      irq_q      <= 1'b0;
    end else begin
      rd_valid_q <= pop;
      irq_q      <= (pop_i.level >= watermark_i);
    end
  end

  // Holds last popped record until the next valid read
  always_ff @(posedge clk_i) begin
    if (pop) begin
      rd_trace_q <= pop_i.head;
    end
  end

  assign rd_valid_o      = rd_valid_q;
  assign rd_trace_o      = rd_trace_q;
  assign watermark_irq_o = irq_q;

  // Back-to-back pulses need a strobe on each of the two cycles before
  a_rd_valid_strobe: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (rd_valid_q && $past(rd_valid_q)) |-> ($past(read_i) && $past(read_i, 2)))
    else $error("rd_valid_o repeated without read strobes");

endmodule

`default_nettype wire

/* source/trace_fifo.sv */
// Trace record FIFO with occupancy level, overflow drop and saturating drop counter
`timescale 1ns/1ps
`include "cfi_trace_defs.svh"
`default_nettype none

module trace_fifo (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  trace_stream_if.sink         stream_i,
  trace_pop_if.fifo            pop_o,
  output cfi_trace_pkg::word_t dropped_count_o
);
  import cfi_trace_pkg::*;

  localparam int unsigned Depth    = `CFI_TRACE_FIFO_DEPTH;
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  trace_t              mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  level_t              level_q;
  word_t               drop_cnt_q;

  logic full;
  logic empty;
  logic pop;
  logic push;
  logic overflow;

  assign full  = (level_q == level_t'(Depth));
  assign empty = (level_q == '0);
  assign pop   = pop_o.pop;
  // A pop in the same cycle frees a slot even when full
  assign push     = stream_i.valid && (!full || pop);
  assign overflow = stream_i.valid && full && !pop;

  // --------------------------------------------------------------------------
  // Pointers, level and drop count
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      drop_cnt_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
      // Saturates at all ones
      if (overflow && (drop_cnt_q != '1)) begin
        drop_cnt_q <= drop_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= stream_i.record;
    end
  end

  assign pop_o.head      = mem_q[rd_ptr_q];
  assign pop_o.level     = level_q;
  assign pop_o.empty     = empty;
  assign dropped_count_o = drop_cnt_q;

  // Reader is responsible for checking empty
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    pop |-> !empty)
    else $error("trace FIFO popped while empty");

  a_level_bound: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    level_q <= level_t'(Depth))
    else $error("trace FIFO level above depth");

endmodule

`default_nettype wire

/* source/trace_formatter.sv */
// Core trace selection and snooper record formatting with one register stage
`timescale 1ns/1ps
`include "cfi_trace_defs.svh"
`default_nettype none

module trace_formatter (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                core_select_i,
  input  cfi_trace_pkg::pc_t                  pc_src_i   [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::pc_t                  pc_dst_i   [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::meta_t                metadata_i [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::priv_lvl_t            priv_lvl_i [`CFI_TRACE_NUM_CORES-1:0],
  input  cfi_trace_pkg::word_t                instr_i    [`CFI_TRACE_NUM_CORES-1:0],
  input  logic [`CFI_TRACE_NUM_CORES-1:0]     pc_valid_i,
  trace_stream_if.source                      stream_o
);
  import cfi_trace_pkg::*;

  localparam int unsigned PcW   = `CFI_TRACE_PC_WIDTH;
  localparam int unsigned WordW = `CFI_TRACE_WORD_WIDTH;
  localparam int unsigned MetaW = `CFI_TRACE_META_WIDTH;

  pc_t    sel_src;
  pc_t    sel_dst;
  trace_t sel_trace;

  trace_t record_q;
  logic   valid_q;
  logic   core_q;

  // --------------------------------------------------------------------------
  // Selection and field rules
  // --------------------------------------------------------------------------
  always_comb begin
    sel_src = pc_src_i[core_select_i];
    sel_dst = pc_dst_i[core_select_i];

    sel_trace.priv_lvl = priv_lvl_i[core_select_i];
    // High words drop bit 63, low words drop bit 0
    sel_trace.pc_src_h = {1'b0, sel_src[PcW-2:WordW]};
    sel_trace.pc_src_l = {sel_src[WordW-1:1], 1'b0};
    sel_trace.pc_dst_h = {1'b0, sel_dst[PcW-2:WordW]};
    sel_trace.pc_dst_l = {sel_dst[WordW-1:1], 1'b0};
    sel_trace.metadata = {{(WordW-MetaW){1'b0}}, metadata_i[core_select_i]};
    sel_trace.opcode   = instr_i[core_select_i];
  end

  // --------------------------------------------------------------------------
  // Output stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
    end else begin
      // Unselected core's valid never gets here
      valid_q <= pc_valid_i[core_select_i];
    end
  end

  always_ff @(posedge clk_i) begin
    record_q <= sel_trace;
    core_q   <= core_select_i;
  end

  assign stream_o.valid  = valid_q;
  assign stream_o.record = record_q;
  assign stream_o.core   = core_q;

endmodule

`default_nettype wire

/* source/trace_pop_if.sv */
// FIFO read side: head record, occupancy, empty flag and pop strobe
`timescale 1ns/1ps
`default_nettype none

interface trace_pop_if;
  import cfi_trace_pkg::*;

  trace_t head;
  level_t level;
  logic   empty;
  // Consumes head at the clock edge
  logic   pop;

  modport fifo (
    output head,
    output level,
    output empty,
    input  pop
  );

  modport reader (
    input  head,
    input  level,
    input  empty,
    output pop
  );

endinterface

`default_nettype wire

/* source/trace_stream_if.sv */
// Formatted trace record stream from formatter to FIFO
`timescale 1ns/1ps
`default_nettype none

interface trace_stream_if;
  import cfi_trace_pkg::*;

  // Single-cycle push strobe
  logic   valid;
  trace_t record;
  // Index of the core the record came from
  logic   core;

  modport source (
    output valid,
    output record,
    output core
  );

  modport sink (
    input valid,
    input record,
    input core
  );

endinterface

`default_nettype wire

/* source/cfi_trace_pkg.sv */
// Trace capture types: privilege level, record word, PC, metadata, FIFO level, trace record
`default_nettype none
`include "cfi_trace_defs.svh"

package cfi_trace_pkg;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  typedef logic [`CFI_TRACE_PC_WIDTH-1:0]   pc_t;
  typedef logic [`CFI_TRACE_WORD_WIDTH-1:0] word_t;
  typedef logic [`CFI_TRACE_META_WIDTH-1:0] meta_t;

  // Occupancy 0 .. depth, inclusive
  typedef logic [$clog2(`CFI_TRACE_FIFO_DEPTH+1)-1:0] level_t;

  // Snooper record layout, 194 bits
  typedef struct packed {
    priv_lvl_t priv_lvl;
    word_t     pc_src_h;
    word_t     pc_src_l;
    word_t     pc_dst_h;
    word_t     pc_dst_l;
    word_t     metadata;
    word_t     opcode;
  } trace_t;

endpackage

`default_nettype wire

/* source/cfi_trace_defs.svh */
// Trace capture macros: core count, program-counter, word and metadata widths, FIFO depth
`ifndef CFI_TRACE_DEFS_SVH
`define CFI_TRACE_DEFS_SVH

// Number of cores feeding the trace path
`define CFI_TRACE_NUM_CORES 2

// Field widths
`define CFI_TRACE_PC_WIDTH   64
`define CFI_TRACE_WORD_WIDTH 32
`define CFI_TRACE_META_WIDTH 4

// Record buffer
`define CFI_TRACE_FIFO_DEPTH 8

`endif
